//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_apb_subsystem
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- hdl/ahb_apb_bridge.sv
/*
 * AHB-lite to APB bridge
 * Each single AHB transfer becomes one APB setup/access pair,
 * with two AHB wait states per transfer
 */
`timescale 1ns/1ps

module ahb_apb_bridge import apb_ss_pkg::*; (
  input  logic     i_hclk,
  input  logic     i_hresetn,     // Synchronous, active low
  // AHB-lite slave side
  input  logic     i_hsel,
  input  addr_t    i_haddr,
  input  htrans_t  i_htrans,
  input  logic     i_hwrite,
  input  data_t    i_hwdata,
  input  logic     i_hready_in,
  output data_t    o_hrdata,
  output logic     o_hready,
  output logic     o_hresp,
  // APB master side
  output apb_req_t o_apb_req,
  input  apb_rsp_t i_apb_rsp
);

  bridge_state_t state_q;
  bridge_state_t state_d;

  logic  xfer_ok;    // Address phase accepted this cycle
  addr_t paddr_q;    // Captured address phase
  logic  pwrite_q;
  data_t pwdata_q;   // Write data held for ACCESS
  data_t pwdata;
  data_t hrdata_q;   // prdata latched on ACCESS

  // ==================================================
  // Address phase
  // ==================================================
  // Only NONSEQ starts a transfer, IDLE/BUSY get zero-wait OKAY
  assign xfer_ok = i_hsel && i_hready_in && (i_htrans == HTRANS_NONSEQ)
                   && (state_q == IDLE);

  always_ff @(posedge i_hclk) begin
    if (xfer_ok) begin
      paddr_q  <= i_haddr;
      pwrite_q <= i_hwrite;
    end
  end

  // ==================================================
  // Transfer FSM
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (xfer_ok) state_d = SETUP;
      SETUP:   state_d = ACCESS;
      ACCESS:  state_d = IDLE;     // Next cycle is the ready cycle
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_hclk) begin
    if (!i_hresetn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==================================================
  // Data phase
  // ==================================================
  // hwdata is valid in the first data cycle, which is SETUP
  always_ff @(posedge i_hclk) begin
    if (state_q == SETUP) begin
      pwdata_q <= i_hwdata;
    end
    if (state_q == ACCESS) begin
      hrdata_q <= i_apb_rsp.prdata;  // Held for the ready cycle
    end
  end

  // Live bus data in SETUP, held copy in ACCESS
  assign pwdata = (state_q == SETUP) ? i_hwdata : pwdata_q;

  assign o_apb_req = '{
    paddr:   paddr_q,
    pwrite:  pwrite_q,
    pwdata:  pwdata,
    penable: (state_q == ACCESS)
  };

  // Wait states during SETUP and ACCESS
  assign o_hready = (state_q == IDLE);
  assign o_hrdata = hrdata_q;
  assign o_hresp  = HRESP_OKAY;

endmodule

//--- hdl/apb_decoder.sv
/*
 * APB address decoder
 * One select per peripheral from paddr[15:12], read data mux back
 */
`timescale 1ns/1ps

module apb_decoder import apb_ss_pkg::*; (
  input  apb_req_t i_apb_req,
  input  apb_rsp_t i_rsp_gpio,
  input  apb_rsp_t i_rsp_uart,
  input  logic     i_active,     // Bridge in SETUP or ACCESS
  output logic     o_psel_gpio,
  output logic     o_psel_uart,
  output apb_rsp_t o_apb_rsp
);

  slv_sel_t slv;
  data_t    rdata;

  assign slv = i_apb_req.paddr[15:12];

  // Selects only while a transfer is in flight
  assign o_psel_gpio = i_active && (slv == SLV_GPIO);
  assign o_psel_uart = i_active && (slv == SLV_UART);

  // Read mux
  always_comb begin
    if (o_psel_gpio) begin
      rdata = i_rsp_gpio.prdata;
    end else if (o_psel_uart) begin
      rdata = i_rsp_uart.prdata;
    end else begin
      rdata = '0;    // Unmapped reads as zero
    end
  end

  assign o_apb_rsp = '{prdata: rdata};

endmodule

//--- hdl/apb_gpio.sv
/*
 * APB GPIO
 * Output and output-enable registers, active-low pin enables,
 * two-flop synchronizer on the input pins
 */
`timescale 1ns/1ps

module apb_gpio import apb_ss_pkg::*; #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  i_pclk,
  input  logic                  i_presetn,
  input  logic                  i_psel,
  input  apb_req_t              i_apb_req,
  input  logic [GPIO_WIDTH-1:0] i_gpio_in,
  output apb_rsp_t              o_apb_rsp,
  output logic [GPIO_WIDTH-1:0] o_gpio_out,
  output logic [GPIO_WIDTH-1:0] o_gpio_oe_n
);

  reg_off_t off;
  logic     wr_en;
  data_t    rdata;

  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] oe_q;     // 1 = pin driven
  logic [GPIO_WIDTH-1:0] in_meta;
  logic [GPIO_WIDTH-1:0] in_sync;

  assign off   = i_apb_req.paddr[3:2];
  assign wr_en = i_psel && i_apb_req.penable && i_apb_req.pwrite;  // Access cycle

  // ==================================================
  // Registers
  // ==================================================
  always_ff @(posedge i_pclk) begin
    if (!i_presetn) begin
      out_q <= '0;
      oe_q  <= '0;      // All pins inputs
    end else if (wr_en) begin
      case (off)
        REG_GPIO_OUT: out_q <= i_apb_req.pwdata[GPIO_WIDTH-1:0];
        REG_GPIO_OE:  oe_q  <= i_apb_req.pwdata[GPIO_WIDTH-1:0];
        default: ;      // IN is read-only
      endcase
    end
  end

  // Pin synchronizer, IN valid 2 cycles after a pin change
  always_ff @(posedge i_pclk) begin
    in_meta <= i_gpio_in;
    in_sync <= in_meta;
  end

  // Read mux
  always_comb begin
    rdata = '0;
    if (i_psel) begin
      case (off)
        REG_GPIO_OUT: rdata = data_t'(out_q);
        REG_GPIO_OE:  rdata = data_t'(oe_q);
        REG_GPIO_IN:  rdata = data_t'(in_sync);
        default:      rdata = '0;
      endcase
    end
  end

  assign o_apb_rsp   = '{prdata: rdata};
  assign o_gpio_out  = out_q;
  assign o_gpio_oe_n = ~oe_q;   // Pads take active-low enables

endmodule

//--- hdl/apb_ss_pkg.sv
/*
 * APB subsystem shared definitions
 * Bus widths, APB request/response structs, address map,
 * register offsets and bridge FSM states
 */
package apb_ss_pkg;

  // ==================================================
  // Bus types
  // ==================================================
  typedef logic [31:0] addr_t;      // AHB/APB address
  typedef logic [31:0] data_t;      // AHB/APB data word
  typedef logic [1:0]  htrans_t;    // AHB transfer type
  typedef logic [3:0]  slv_sel_t;   // Peripheral field, haddr[15:12]
  typedef logic [1:0]  reg_off_t;   // Register offset, haddr[3:2]
  typedef logic [15:0] uart_div_t;  // Baud divisor
  typedef logic [7:0]  byte_t;      // UART character

  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam logic    HRESP_OKAY    = 1'b0;  // Only response ever given

  // Bridge to slaves, 66 bits
  typedef struct packed {
    addr_t paddr;
    logic  pwrite;
    data_t pwdata;
    logic  penable;
  } apb_req_t;

  // Slave back to bridge
  typedef struct packed {
    data_t prdata;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    IDLE,    // Waiting for an AHB transfer
    SETUP,   // APB setup, psel up, penable low
    ACCESS   // APB access, penable high
  } bridge_state_t;

  // ==================================================
  // Address map
  // ==================================================
  localparam slv_sel_t SLV_GPIO = 4'd0;
  localparam slv_sel_t SLV_UART = 4'd1;

  localparam reg_off_t REG_GPIO_OUT  = 2'd0;
  localparam reg_off_t REG_GPIO_OE   = 2'd1;
  localparam reg_off_t REG_GPIO_IN   = 2'd2;

  localparam reg_off_t REG_UART_DATA = 2'd0;
  localparam reg_off_t REG_UART_STAT = 2'd1;
  localparam reg_off_t REG_UART_DIV  = 2'd2;

endpackage

//--- hdl/apb_subsystem.sv
/*
 * APB peripheral subsystem top
 * AHB-lite slave port, bridge, decoder, GPIO and UART
 */
`timescale 1ns/1ps

module apb_subsystem import apb_ss_pkg::*; #(
  parameter int        GPIO_WIDTH = 16,
  parameter uart_div_t DIV_RESET  = 16'd8
) (
  input  logic                  i_hclk,
  input  logic                  i_hresetn,
  // AHB-lite slave
  input  logic                  i_hsel,
  input  addr_t                 i_haddr,
  input  htrans_t               i_htrans,
  input  logic                  i_hwrite,
  input  logic [2:0]            i_hsize,     // Word accesses only, not decoded
  input  data_t                 i_hwdata,
  input  logic                  i_hready_in,
  output data_t                 o_hrdata,
  output logic                  o_hready,
  output logic                  o_hresp,
  // Pins
  input  logic [GPIO_WIDTH-1:0] i_gpio_in,
  output logic [GPIO_WIDTH-1:0] o_gpio_out,
  output logic [GPIO_WIDTH-1:0] o_gpio_oe_n,
  input  logic                  i_uart_rxd,
  output logic                  o_uart_txd,
  output logic                  o_uart_irq
);

  apb_req_t apb_req;
  apb_rsp_t apb_rsp, rsp_gpio, rsp_uart;
  logic     psel_gpio, psel_uart;

  ahb_apb_bridge bridge_i (
    .i_hclk (i_hclk), .i_hresetn (i_hresetn),
    .i_hsel (i_hsel), .i_haddr (i_haddr), .i_htrans (i_htrans),
    .i_hwrite (i_hwrite), .i_hwdata (i_hwdata), .i_hready_in (i_hready_in),
    .o_hrdata (o_hrdata), .o_hready (o_hready), .o_hresp (o_hresp),
    .o_apb_req (apb_req), .i_apb_rsp (apb_rsp)
  );

  // Bridge is mid-transfer whenever it holds hready low
  apb_decoder decoder_i (
    .i_apb_req (apb_req), .i_rsp_gpio (rsp_gpio), .i_rsp_uart (rsp_uart),
    .i_active (!o_hready),
    .o_psel_gpio (psel_gpio), .o_psel_uart (psel_uart), .o_apb_rsp (apb_rsp)
  );

  apb_gpio #(.GPIO_WIDTH (GPIO_WIDTH)) gpio_i (
    .i_pclk (i_hclk), .i_presetn (i_hresetn), .i_psel (psel_gpio),
    .i_apb_req (apb_req), .i_gpio_in (i_gpio_in), .o_apb_rsp (rsp_gpio),
    .o_gpio_out (o_gpio_out), .o_gpio_oe_n (o_gpio_oe_n)
  );

  apb_uart #(.DIV_RESET (DIV_RESET)) uart_i (
    .i_pclk (i_hclk), .i_presetn (i_hresetn), .i_psel (psel_uart),
    .i_apb_req (apb_req), .i_rxd (i_uart_rxd), .o_apb_rsp (rsp_uart),
    .o_txd (o_uart_txd), .o_irq (o_uart_irq)
  );

endmodule

//--- hdl/apb_uart.sv
/*
 * APB UART, 8N1
 * Baud divisor register, transmit shifter, mid-bit receive sampler,
 * status register and receive interrupt
 */
`timescale 1ns/1ps

module apb_uart import apb_ss_pkg::*; #(
  parameter uart_div_t DIV_RESET = 16'd8
) (
  input  logic     i_pclk,
  input  logic     i_presetn,
  input  logic     i_psel,
  input  apb_req_t i_apb_req,
  input  logic     i_rxd,
  output apb_rsp_t o_apb_rsp,
  output logic     o_txd,
  output logic     o_irq
);

  reg_off_t  off;
  logic      wr_en, rd_en;
  data_t     rdata;
  uart_div_t div_q;      // Bit time is div_q+1 clocks

  logic       tx_busy;
  logic [9:0] tx_shift;  // {stop, data, start}, LSB on the line
  uart_div_t  tx_cnt;
  logic [3:0] tx_bitcnt;

  logic [2:0] rx_pipe;   // [1] synchronized, [2] previous
  logic       rx_bit, start_edge;
  logic       rx_busy, rx_valid, rx_sample, rx_done;
  uart_div_t  rx_cnt;
  logic [3:0] rx_bitcnt; // 0 start, 1..8 data, 9 stop
  byte_t      rx_shift, rx_buf;

  assign off   = i_apb_req.paddr[3:2];
  assign wr_en = i_psel && i_apb_req.penable && i_apb_req.pwrite;
  assign rd_en = i_psel && i_apb_req.penable && !i_apb_req.pwrite;

  always_ff @(posedge i_pclk) begin
    if (!i_presetn) begin
      div_q <= DIV_RESET;
    end else if (wr_en && off == REG_UART_DIV) begin
      div_q <= i_apb_req.pwdata[15:0];
    end
  end

  // ==================================================
  // Transmitter
  // ==================================================
  always_ff @(posedge i_pclk) begin
    if (!i_presetn) begin
      tx_busy   <= 1'b0;
      tx_shift  <= '1;      // Line idles high
      tx_cnt    <= '0;
      tx_bitcnt <= '0;
    end else if (!tx_busy) begin
      if (wr_en && off == REG_UART_DATA) begin   // Writes while busy dropped
        tx_shift  <= {1'b1, i_apb_req.pwdata[7:0], 1'b0};
        tx_busy   <= 1'b1;
        tx_cnt    <= '0;
        tx_bitcnt <= '0;
      end
    end else if (tx_cnt == div_q) begin
      tx_cnt    <= '0;
      tx_shift  <= {1'b1, tx_shift[9:1]};         // Refill with idle level
      tx_bitcnt <= tx_bitcnt + 4'd1;
      if (tx_bitcnt == 4'd9) tx_busy <= 1'b0;    // Stop bit done
    end else begin
      tx_cnt <= tx_cnt + 16'd1;
    end
  end

  assign o_txd = tx_shift[0];

  // ==================================================
  // Receiver
  // ==================================================
  assign rx_bit     = rx_pipe[1];
  assign start_edge = !rx_pipe[1] && rx_pipe[2];
  assign rx_sample  = rx_busy && (rx_cnt == '0);
  assign rx_done    = rx_sample && (rx_bitcnt == 4'd9) && rx_bit;  // Good stop bit

  always_ff @(posedge i_pclk) begin
    if (!i_presetn) begin
      rx_pipe   <= '1;
      rx_busy   <= 1'b0;
      rx_valid  <= 1'b0;
      rx_cnt    <= '0;
      rx_bitcnt <= '0;
    end else begin
      rx_pipe <= {rx_pipe[1:0], i_rxd};
      if (rd_en && off == REG_UART_DATA) rx_valid <= 1'b0;
      if (!rx_busy) begin
        if (start_edge) begin
          rx_busy   <= 1'b1;
          rx_cnt    <= div_q >> 1;     // Half a bit to mid start
          rx_bitcnt <= '0;
        end
      end else if (!rx_sample) begin
        rx_cnt <= rx_cnt - 16'd1;
      end else begin
        rx_cnt    <= div_q;
        rx_bitcnt <= rx_bitcnt + 4'd1;
        if ((rx_bitcnt == 4'd0 && rx_bit) || rx_bitcnt == 4'd9) begin
          rx_busy <= 1'b0;             // False start or frame end
        end
      end
      if (rx_done) rx_valid <= 1'b1;   // Wins over a same-cycle read
    end
  end

  // Data shifts in LSB first, buffer overwritten if still unread
  always_ff @(posedge i_pclk) begin
    if (rx_sample && rx_bitcnt != 4'd0 && rx_bitcnt != 4'd9) begin
      rx_shift <= {rx_bit, rx_shift[7:1]};
    end
    if (rx_done) rx_buf <= rx_shift;
  end

  // Read mux
  always_comb begin
    rdata = '0;
    if (i_psel) begin
      case (off)
        REG_UART_DATA: rdata = {24'b0, rx_buf};
        REG_UART_STAT: rdata = {30'b0, rx_valid, tx_busy};
        REG_UART_DIV:  rdata = {16'b0, div_q};
        default:       rdata = '0;
      endcase
    end
  end

  assign o_apb_rsp = '{prdata: rdata};
  assign o_irq     = rx_valid;

endmodule

//--- src.f
hdl/apb_ss_pkg.sv
hdl/ahb_apb_bridge.sv
hdl/apb_decoder.sv
hdl/apb_gpio.sv
hdl/apb_uart.sv
hdl/apb_subsystem.sv
testbench/apb_subsystem_chk.sv
testbench/tb_apb_subsystem.sv

//--- testbench/apb_subsystem_chk.sv
/*
 * Protocol checker bound into the APB subsystem
 * AHB wait states, APB setup/access order, select exclusivity, UART idle level
 */
`timescale 1ns/1ps

module apb_subsystem_chk import apb_ss_pkg::*; (
  input logic    i_hclk,
  input logic    i_hresetn,
  input logic    i_hsel,
  input htrans_t i_htrans,
  input logic    i_hready_in,
  input logic    i_hready,     // DUT o_hready
  input logic    i_psel_gpio,
  input logic    i_psel_uart,
  input logic    i_penable,
  input logic    i_txd,
  input logic    i_tx_busy
);

  logic accept;
  logic idle_req;
  logic psel_any;

  assign accept   = i_hsel && i_hready_in && i_hready && (i_htrans == HTRANS_NONSEQ);
  assign idle_req = i_hsel && i_hready_in && i_hready && (i_htrans == HTRANS_IDLE);
  assign psel_any = i_psel_gpio || i_psel_uart;

  // Setup and access wait states, ready in third data cycle
  a_two_waits: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    accept |=> !i_hready ##1 !i_hready ##1 i_hready)
    else $error("o_hready not low for exactly two cycles after accept");

  a_idle_okay: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    idle_req |=> i_hready)   // Zero-wait IDLE
    else $error("IDLE transfer got a wait state");

  // One setup cycle, one access cycle, then select drops
  a_setup_access: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    $rose(psel_any) |-> !i_penable ##1 (psel_any && i_penable) ##1 !psel_any)
    else $error("penable did not follow psel by one cycle");

  a_one_sel: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    !(i_psel_gpio && i_psel_uart))
    else $error("more than one psel high");

  a_tx_idle: assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    !i_tx_busy |-> i_txd)    // Line idles high
    else $error("UART line low while transmitter idle");

endmodule

bind apb_subsystem apb_subsystem_chk chk_i (
  .i_hclk (i_hclk), .i_hresetn (i_hresetn), .i_hsel (i_hsel), .i_htrans (i_htrans),
  .i_hready_in (i_hready_in), .i_hready (o_hready),
  .i_psel_gpio (psel_gpio), .i_psel_uart (psel_uart), .i_penable (apb_req.penable),
  .i_txd (o_uart_txd), .i_tx_busy (uart_i.tx_busy)
);

//--- testbench/tb_apb_subsystem.sv
/*
 * Testbench for the APB subsystem
 * Single AHB master, UART looped back, GPIO pins driven from outside
 */
`timescale 1ns/1ps

module tb_apb_subsystem import apb_ss_pkg::*; ();

  localparam int        GPIO_W   = 16;
  localparam uart_div_t DIV_RST  = 16'd8;
  localparam int        TIMEOUT  = 5000;             // Cycles per wait
  localparam data_t     PIN_MASK = data_t'({GPIO_W{1'b1}});

  logic tb_hclk12, hresetn12;
  logic hsel, hwrite, hready_in, hready, hresp;
  addr_t haddr;
  htrans_t htrans;
  logic [2:0] hsize;
  data_t hwdata, hrdata;
  logic [GPIO_W-1:0] gpio_drv, gpio_in, gpio_out, gpio_oe_n;
  logic uart_txd, uart_rxd, uart_irq;
  logic [31:0] rng_state;

  // Enabled pins read back their own output
  assign gpio_in  = (gpio_drv & gpio_oe_n) | (gpio_out & ~gpio_oe_n);
  assign uart_rxd = hresetn12 ? uart_txd : 1'b1;   // Serial loopback

  apb_subsystem #(.GPIO_WIDTH (GPIO_W), .DIV_RESET (DIV_RST)) dut_i (
    .i_hclk (tb_hclk12), .i_hresetn (hresetn12), .i_hsel (hsel), .i_haddr (haddr),
    .i_htrans (htrans), .i_hwrite (hwrite), .i_hsize (hsize), .i_hwdata (hwdata),
    .i_hready_in (hready_in), .o_hrdata (hrdata), .o_hready (hready), .o_hresp (hresp),
    .i_gpio_in (gpio_in), .o_gpio_out (gpio_out), .o_gpio_oe_n (gpio_oe_n),
    .i_uart_rxd (uart_rxd), .o_uart_txd (uart_txd), .o_uart_irq (uart_irq)
  );

  initial begin
    tb_hclk12 = 1'b0;
    forever #20 tb_hclk12 = ~tb_hclk12;
  end

  // ==================================================
  // Helpers
  // ==================================================
  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Peripheral in [15:12], register in [3:2]
  function automatic addr_t reg_addr(slv_sel_t s, reg_off_t r);
    return {16'h0000, s, 8'h00, r, 2'b00};
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(string name, data_t got, data_t exp);
    assert (got === exp) else begin
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic drive_addr(logic wr, addr_t a);
    @(posedge tb_hclk12);
    hsel   <= 1'b1;
    haddr  <= a;
    htrans <= HTRANS_NONSEQ;
    hwrite <= wr;
  endtask

  // Returns at the falling edge of a ready cycle
  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge tb_hclk12);
    while (!hready) begin
      n++;
      if (n > TIMEOUT) abort_run("timeout waiting for o_hready");
      @(negedge tb_hclk12);
    end
    check_eq("o_hresp", data_t'(hresp), 32'd0);   // OKAY on every ready cycle
  endtask

  task automatic ahb_write(addr_t a, data_t d);
    drive_addr(1'b1, a);
    wait_ready();
    @(posedge tb_hclk12);              // Accepted here, data phase starts
    htrans <= HTRANS_IDLE;
    hsel   <= 1'b0;
    hwdata <= d;
    wait_ready();
  endtask

  task automatic ahb_read(addr_t a, output data_t d);
    drive_addr(1'b0, a);
    wait_ready();
    @(posedge tb_hclk12);
    htrans <= HTRANS_IDLE;
    hsel   <= 1'b0;
    wait_ready();
    d = hrdata;                        // Valid in the ready cycle
  endtask

  task automatic read_check(addr_t a, data_t exp, string name);
    data_t d;
    ahb_read(a, d);
    check_eq(name, d, exp);
  endtask

  // Write then read with the read address overlapping the write data phase
  task automatic ahb_b2b(addr_t wa, data_t wd, addr_t ra, output data_t rd);
    drive_addr(1'b1, wa);
    wait_ready();
    @(posedge tb_hclk12);
    hwdata <= wd;
    haddr  <= ra;
    hwrite <= 1'b0;
    wait_ready();                      // Read address taken at end of this cycle
    @(posedge tb_hclk12);
    htrans <= HTRANS_IDLE;
    hsel   <= 1'b0;
    wait_ready();
    rd = hrdata;
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    @(negedge tb_hclk12);
    while (!uart_irq) begin
      n++;
      if (n > TIMEOUT) abort_run("timeout waiting for o_uart_irq");
      @(negedge tb_hclk12);
    end
  endtask

  task automatic wait_tx_idle();
    data_t st;
    int n;
    n = 0;
    ahb_read(reg_addr(SLV_UART, REG_UART_STAT), st);
    while (st[0]) begin                // tx_busy
      n++;
      if (n > TIMEOUT) abort_run("timeout waiting for UART transmitter idle");
      ahb_read(reg_addr(SLV_UART, REG_UART_STAT), st);
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin : main
    data_t rd, v_out, v_oe, drv;
    uart_div_t div;
    byte_t ch;
    rng_state = 32'd7;
    hresetn12 = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = HTRANS_IDLE;
    hwrite    = 1'b0;
    hsize     = 3'b010;                // Word
    hwdata    = '0;
    hready_in = 1'b1;
    gpio_drv  = '0;
    repeat (16) @(posedge tb_hclk12);
    hresetn12 <= 1'b1;
    @(negedge tb_hclk12);

    // Reset state
    check_eq("o_hready", data_t'(hready), 32'd1);
    check_eq("o_gpio_oe_n", data_t'(gpio_oe_n), PIN_MASK);
    check_eq("o_uart_txd", data_t'(uart_txd), 32'd1);
    check_eq("o_uart_irq", data_t'(uart_irq), 32'd0);
    read_check(reg_addr(SLV_GPIO, REG_GPIO_OUT), 32'd0, "gpio OUT");
    read_check(reg_addr(SLV_UART, REG_UART_STAT), 32'd0, "uart STAT");
    read_check(reg_addr(SLV_UART, REG_UART_DIV), data_t'(DIV_RST), "uart DIV");

    // GPIO outputs, mixed enables
    repeat (4) begin
      v_out = xorshift() & PIN_MASK;
      v_oe  = xorshift() & PIN_MASK;
      ahb_write(reg_addr(SLV_GPIO, REG_GPIO_OUT), v_out);
      ahb_write(reg_addr(SLV_GPIO, REG_GPIO_OE), v_oe);
      read_check(reg_addr(SLV_GPIO, REG_GPIO_OUT), v_out, "gpio OUT");
      read_check(reg_addr(SLV_GPIO, REG_GPIO_OE), v_oe, "gpio OE");
      check_eq("o_gpio_out", data_t'(gpio_out), v_out);
      check_eq("o_gpio_oe_n", data_t'(gpio_oe_n), ~v_oe & PIN_MASK);
      drv = xorshift();
      @(posedge tb_hclk12);
      gpio_drv <= drv[GPIO_W-1:0];
      repeat (2) @(posedge tb_hclk12); // Synchronizer depth
      read_check(reg_addr(SLV_GPIO, REG_GPIO_IN),
                 ((drv & ~v_oe) | (v_out & v_oe)) & PIN_MASK, "gpio IN");
    end

    // GPIO inputs only
    ahb_write(reg_addr(SLV_GPIO, REG_GPIO_OE), 32'd0);
    repeat (3) begin
      drv = xorshift();
      @(posedge tb_hclk12);
      gpio_drv <= drv[GPIO_W-1:0];
      repeat (2) @(posedge tb_hclk12);
      read_check(reg_addr(SLV_GPIO, REG_GPIO_IN), drv & PIN_MASK, "gpio IN");
    end

    // UART loopback, random divisor per byte
    repeat (4) begin
      rd  = xorshift();
      div = {13'd0, rd[2:0]} + 16'd2;
      ch  = rd[15:8];
      ahb_write(reg_addr(SLV_UART, REG_UART_DIV), data_t'(div));
      ahb_write(reg_addr(SLV_UART, REG_UART_DATA), data_t'(ch));
      wait_irq();
      read_check(reg_addr(SLV_UART, REG_UART_DATA), data_t'(ch), "uart DATA");
      check_eq("o_uart_irq", data_t'(uart_irq), 32'd0);
      wait_tx_idle();
    end
    read_check(reg_addr(SLV_UART, REG_UART_STAT), 32'd0, "uart STAT");

    // ==================================================
    // Unmapped space and back-to-back transfers
    // ==================================================
    ahb_b2b(reg_addr(4'd2, REG_GPIO_OUT), xorshift(), reg_addr(4'd2, REG_GPIO_OUT), rd);
    check_eq("o_hrdata", rd, 32'd0);
    ahb_b2b(reg_addr(4'hf, REG_UART_DIV), xorshift(), reg_addr(4'hf, REG_UART_DIV), rd);
    check_eq("o_hrdata", rd, 32'd0);
    // Registers keep the last values written above
    read_check(reg_addr(SLV_GPIO, REG_GPIO_OUT), v_out, "gpio OUT");
    read_check(reg_addr(SLV_GPIO, REG_GPIO_OE), 32'd0, "gpio OE");
    read_check(reg_addr(SLV_UART, REG_UART_DIV), data_t'(div), "uart DIV");
    read_check(reg_addr(SLV_UART, REG_UART_STAT), 32'd0, "uart STAT");
    drv = xorshift() & PIN_MASK;
    ahb_b2b(reg_addr(SLV_GPIO, REG_GPIO_OUT), drv, reg_addr(SLV_GPIO, REG_GPIO_OUT), rd);
    check_eq("gpio OUT", rd, drv);

    // Selected IDLE transfers, zero wait
    @(posedge tb_hclk12);
    hsel   <= 1'b1;
    htrans <= HTRANS_IDLE;
    repeat (3) @(posedge tb_hclk12);
    hsel <= 1'b0;
    wait_ready();

    $display("TEST OK");
    $finish;
  end

endmodule
